// ==== project.f ====
hw/csr_pkg.sv
hw/irq_select.sv
hw/csr_regfile.sv
hw/csr_decode.sv
hw/csr_exec.sv
hw/csr_top.sv
test/csr_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Compile with Verilator and run the CSR testbench

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f project.f --top-module csr_tb \
  --Mdir obj_dir -o csr_tb_sim > build.log 2>&1
status=$?
if [ $status -ne 0 ]; then
  cat build.log
  echo "Verilator build returned status $status"
  exit 1
fi

./obj_dir/csr_tb_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation returned status $status"
  exit 1
fi

if grep -qx "Verification passed" sim.log; then
  exit 0
fi
exit 1

// ==== test/csr_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_tb
  import csr_pkg::*;
();

  localparam int unsigned HART_ID_TB = 5;
  localparam int          RESULT_TIMEOUT = 20;

  logic        clk_i;
  logic        rst_n_i;
  csr_cmd_t    csr_cmd_i;
  logic        csr_cmd_v_i;
  logic        timer_irq_i;
  logic        software_irq_i;
  logic        external_irq_i;
  logic        instret_i;
  csr_result_t csr_result_o;
  logic        result_v_o;
  priv_e       priv_mode_o;

  // Reference model state
  logic [63:0] m_mscratch;
  logic [63:0] m_mtvec;
  logic [63:0] m_mepc;
  logic [63:0] m_mcause;
  logic [63:0] m_mtval;
  logic [63:0] m_minstret;
  logic        m_gie;
  logic        m_mpie;
  logic [1:0]  m_mpp;
  logic [1:0]  m_priv;
  // Bit 0 software, bit 1 timer, bit 2 external
  logic [2:0]  m_ien;
  logic [2:0]  irq_lvl;

  csr_result_t exp_q[$];
  logic        chk_q[$];
  int          cyc_q[$];

  logic [31:0] lfsr = 32'h70f7d05a;
  logic [63:0] pc_next = 64'h8000_0000;
  int          cyc_cnt = 0;
  int          cmp_errors = 0;
  int          cmp_checks = 0;
  int          tb_errors = 0;
  int          tb_checks = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          errors_at_start = 0;
  string       test_name = "reset";

  csr_result_t cmp_exp;
  logic        cmp_chk;
  int          cmp_cyc;
  logic [63:0] last_data;
  logic        last_intr;
  logic [3:0]  last_cause;

  csr_top #(
    .HART_ID(HART_ID_TB)
  ) u_csr_top (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .csr_cmd_i     (csr_cmd_i),
    .csr_cmd_v_i   (csr_cmd_v_i),
    .timer_irq_i   (timer_irq_i),
    .software_irq_i(software_irq_i),
    .external_irq_i(external_irq_i),
    .instret_i     (instret_i),
    .csr_result_o  (csr_result_o),
    .result_v_o    (result_v_o),
    .priv_mode_o   (priv_mode_o)
  );

  initial
  begin
    clk_i = 1'b0;
    forever
      #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i)
    cyc_cnt <= cyc_cnt + 1;

  // Taps 32, 22, 2, 1
  function automatic logic [63:0] rand_bits(input int n);
    logic [63:0] v;
    logic        b;
    int          i;
    v = '0;
    for (i = 0; i < n; i++)
    begin
      b    = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], b};
      v    = {v[62:0], b};
    end
    return v;
  endfunction

  function automatic logic [63:0] model_read(input logic [11:0] addr, output logic known);
    known = 1'b1;
    case (addr)
      ADDR_MSTATUS:   return (64'(m_mpp) << 11) | (64'(m_mpie) << 7) | (64'(m_gie) << 3);
      ADDR_MISA:      return (64'd2 << 62) | (64'd1 << 20) | (64'd1 << 12) | (64'd1 << 8) | 64'd1;
      ADDR_MIE:       return (64'(m_ien[2]) << 11) | (64'(m_ien[1]) << 7) | (64'(m_ien[0]) << 3);
      ADDR_MTVEC:     return m_mtvec;
      ADDR_MSCRATCH:  return m_mscratch;
      ADDR_MEPC:      return m_mepc;
      ADDR_MCAUSE:    return m_mcause;
      ADDR_MTVAL:     return m_mtval;
      ADDR_MIP:
        return (64'(irq_lvl[2]) << 11) | (64'(irq_lvl[1]) << 7) | (64'(irq_lvl[0]) << 3);
      ADDR_MCYCLE:    return 64'd0;
      ADDR_MINSTRET:  return m_minstret;
      ADDR_MVENDORID: return 64'd0;
      ADDR_MARCHID:   return 64'd13;
      ADDR_MIMPID:    return 64'd1;
      ADDR_MHARTID:   return 64'(HART_ID_TB);
      default:
      begin
        known = 1'b0;
        return 64'd0;
      end
    endcase
  endfunction

  function automatic void model_write(input logic [11:0] addr, input logic [63:0] v);
    case (addr)
      ADDR_MSTATUS:
      begin
        m_gie  = v[3];
        m_mpie = v[7];
        m_mpp  = (v[12:11] == 2'b11) ? PRIV_M : PRIV_U;
      end
      ADDR_MIE:      m_ien      = {v[11], v[7], v[3]};
      ADDR_MTVEC:    m_mtvec    = v;
      ADDR_MSCRATCH: m_mscratch = v;
      ADDR_MEPC:     m_mepc     = v;
      ADDR_MCAUSE:   m_mcause   = v;
      ADDR_MTVAL:    m_mtval    = v;
      ADDR_MINSTRET: m_minstret = v;
      default:       ;
    endcase
  endfunction

  // Expected result of one command and the matching model update
  function automatic csr_result_t ref_model(input csr_cmd_t c);
    csr_result_t r;
    logic [63:0] old;
    logic [63:0] src;
    logic [63:0] nv;
    logic [2:0]  pend;
    logic [3:0]  cause;
    logic        known;
    logic        rmw;
    logic        wr;
    logic        ill;
    logic        ecall;
    logic        irq;
    logic        gie;
    r     = '0;
    old   = model_read(c.addr, known);
    rmw   = c.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC, OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    src   = (c.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI}) ? {59'b0, c.data[4:0]} : c.data;
    wr    = (c.op inside {OP_CSRRW, OP_CSRRWI}) || (src != 64'd0);
    ill   = 1'b0;
    if (rmw)
      ill = !known || (c.addr[9:8] > m_priv) || ((c.addr[11:10] == 2'b11) && wr);
    else if (c.op == OP_MRET)
      ill = (m_priv != PRIV_M);
    ecall = (c.op == OP_ECALL);
    gie   = (m_priv == PRIV_M) ? m_gie : 1'b1;
    pend  = m_ien & irq_lvl;
    irq   = !ill && !ecall && gie && (pend != 3'b000);
    if (ill)
      cause = 4'd2;
    else if (ecall)
      cause = (m_priv == PRIV_U) ? 4'd8 : 4'd11;
    else if (pend[2])
      cause = 4'd11;
    else if (pend[0])
      cause = 4'd3;
    else
      cause = 4'd7;

    if (ill || ecall || irq)
    begin
      m_mepc    = c.pc;
      m_mcause  = {irq, 59'b0, cause};
      m_mtval   = ill ? {32'b0, c.instr} : 64'd0;
      m_mpp     = m_priv;
      m_mpie    = m_gie;
      m_gie     = 1'b0;
      m_priv    = PRIV_M;
      r.cause   = cause;
      r.next_pc = {m_mtvec[63:2], 2'b00};
    end
    else if (c.op == OP_MRET)
    begin
      m_priv    = m_mpp;
      m_gie     = m_mpie;
      m_mpie    = 1'b1;
      m_mpp     = PRIV_U;
      r.eret    = 1'b1;
      r.next_pc = m_mepc;
    end
    else if (rmw)
    begin
      r.data = old;
      if (wr)
      begin
        case (c.op)
          OP_CSRRW, OP_CSRRWI: nv = src;
          OP_CSRRS, OP_CSRRSI: nv = old | src;
          default:             nv = old & ~src;
        endcase
        model_write(c.addr, nv);
      end
    end
    r.illegal   = ill;
    r.exception = ill || ecall;
    r.interrupt = irq;
    r.priv_n    = priv_e'(m_priv);
    return r;
  endfunction

  // Compare process with one result per command
  always @(negedge clk_i)
  begin
    if (rst_n_i && result_v_o)
    begin
      cmp_checks++;
      if (exp_q.size() == 0)
      begin
        cmp_errors++;
        $display("A result arrived with no command outstanding in test %s", test_name);
      end
      else
      begin
        cmp_exp = exp_q.pop_front();
        cmp_chk = chk_q.pop_front();
        cmp_cyc = cyc_q.pop_front();
        // Counter value is free running
        if (!cmp_chk)
          cmp_exp.data = csr_result_o.data;
        assert (cyc_cnt == cmp_cyc)
        else
        begin
          cmp_errors++;
          $display("Result in test %s came at cycle %0d instead of cycle %0d",
                   test_name, cyc_cnt, cmp_cyc);
        end
        assert (csr_result_o == cmp_exp)
        else
        begin
          cmp_errors++;
          $display("Mismatch in %s: expected %h, actual %h", test_name, cmp_exp, csr_result_o);
        end
        assert (priv_mode_o == cmp_exp.priv_n)
        else
        begin
          cmp_errors++;
          $display("Mismatch in %s: expected mode %0d, actual mode %0d",
                   test_name, cmp_exp.priv_n, priv_mode_o);
        end
      end
      last_data  = csr_result_o.data;
      last_intr  = csr_result_o.interrupt;
      last_cause = csr_result_o.cause;
    end
  end

  task automatic send_cmd(input csr_op_e op, input logic [11:0] addr, input logic [63:0] data);
    csr_cmd_t c;
    c.op    = op;
    c.addr  = addr;
    c.data  = data;
    c.pc    = pc_next;
    c.instr = 32'(rand_bits(32));
    pc_next = pc_next + 64'd4;
    exp_q.push_back(ref_model(c));
    chk_q.push_back(addr != ADDR_MCYCLE);
    cyc_q.push_back(cyc_cnt + 2);
    csr_cmd_i   = c;
    csr_cmd_v_i = 1'b1;
    @(negedge clk_i);
    csr_cmd_v_i = 1'b0;
  endtask

  task automatic wait_results(input int limit);
    int n;
    n = 0;
    while (exp_q.size() != 0 && n < limit)
    begin
      @(negedge clk_i);
      n++;
    end
    if (exp_q.size() != 0)
    begin
      tb_errors++;
      $display("Timed out waiting for %0d results in test %s", exp_q.size(), test_name);
      exp_q.delete();
      chk_q.delete();
      cyc_q.delete();
    end
  endtask

  task automatic set_irq_lines(input logic [2:0] lvl);
    irq_lvl        = lvl;
    software_irq_i = lvl[0];
    timer_irq_i    = lvl[1];
    external_irq_i = lvl[2];
  endtask

  // Plain commands until one is taken as an interrupt
  task automatic wait_for_interrupt(input int limit);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done && n < limit)
    begin
      send_cmd(OP_NONE, 12'h000, 64'd0);
      wait_results(RESULT_TIMEOUT);
      done = last_intr;
      n++;
    end
    tb_checks++;
    if (!done)
    begin
      tb_errors++;
      $display("No interrupt was taken within %0d commands in test %s", limit, test_name);
    end
  endtask

  task automatic read_trap_csrs();
    send_cmd(OP_CSRRS, ADDR_MCAUSE, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MEPC, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MTVAL, 64'd0);
    wait_results(RESULT_TIMEOUT);
  endtask

  task automatic start_test(input string name);
    test_name       = name;
    errors_at_start = cmp_errors + tb_errors;
  endtask

  task automatic end_test();
    int errs;
    errs = cmp_errors + tb_errors - errors_at_start;
    tests_run++;
    if (errs == 0)
      $display("Test %s: ok", test_name);
    else
    begin
      tests_failed++;
      $display("Test %s: %0d errors", test_name, errs);
    end
  endtask

  initial
  begin
    int          i;
    int          k;
    logic [63:0] t0;
    logic [63:0] t1;
    rst_n_i     = 1'b0;
    csr_cmd_i   = '0;
    csr_cmd_v_i = 1'b0;
    instret_i   = 1'b0;
    set_irq_lines(3'b000);
    m_mscratch = '0;
    m_mtvec    = '0;
    m_mepc     = '0;
    m_mcause   = '0;
    m_mtval    = '0;
    m_minstret = '0;
    m_gie      = 1'b0;
    m_mpie     = 1'b0;
    m_mpp      = PRIV_U;
    m_priv     = PRIV_M;
    m_ien      = 3'b000;

    start_test("reset");
    repeat (10) @(negedge clk_i);
    rst_n_i = 1'b1;
    @(negedge clk_i);
    tb_checks++;
    assert ({result_v_o, csr_result_o} == '0)
    else
    begin
      tb_errors++;
      $display("Mismatch in %s: expected %h, actual %h", test_name, 0, {result_v_o, csr_result_o});
    end
    assert (priv_mode_o == PRIV_M)
    else
    begin
      tb_errors++;
      $display("Mismatch in %s: expected %0d, actual %0d", test_name, PRIV_M, priv_mode_o);
    end
    end_test();

    start_test("rmw_random");
    for (i = 0; i < 48; i++)
    begin
      k  = int'(rand_bits(3) % 64'd6);
      t0 = rand_bits(64);
      if (rand_bits(1) != 64'd0)
        send_cmd(csr_op_e'(k), ADDR_MTVEC, t0);
      else
        send_cmd(csr_op_e'(k), ADDR_MSCRATCH, t0);
    end
    send_cmd(OP_CSRRS, ADDR_MSCRATCH, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MTVEC, 64'd0);
    wait_results(RESULT_TIMEOUT);
    end_test();

    start_test("identity");
    send_cmd(OP_CSRRS, ADDR_MISA, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MARCHID, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MIMPID, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MHARTID, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MVENDORID, 64'd0);
    wait_results(RESULT_TIMEOUT);
    send_cmd(OP_CSRRW, ADDR_MISA, rand_bits(64));
    read_trap_csrs();
    send_cmd(OP_CSRRSI, ADDR_MHARTID, 64'd1);
    read_trap_csrs();
    // pmpcfg0 is not implemented here
    send_cmd(OP_CSRRS, 12'h3a0, 64'd0);
    read_trap_csrs();
    end_test();

    start_test("ecall_mret");
    send_cmd(OP_ECALL, 12'h000, 64'd0);
    send_cmd(OP_CSRRC, ADDR_MSTATUS, 64'h1800);
    send_cmd(OP_CSRRW, ADDR_MEPC, rand_bits(64));
    send_cmd(OP_MRET, 12'h000, 64'd0);
    send_cmd(OP_CSRRS, ADDR_MSCRATCH, 64'd0);
    send_cmd(OP_MRET, 12'h000, 64'd0);
    send_cmd(OP_MRET, 12'h000, 64'd0);
    send_cmd(OP_MRET, 12'h000, 64'd0);
    send_cmd(OP_ECALL, 12'h000, 64'd0);
    wait_results(RESULT_TIMEOUT);
    read_trap_csrs();
    end_test();

    start_test("timer_irq");
    send_cmd(OP_CSRRS, ADDR_MIE, 64'h80);
    send_cmd(OP_CSRRW, ADDR_MEPC, rand_bits(64));
    send_cmd(OP_CSRRC, ADDR_MSTATUS, 64'h1800);
    send_cmd(OP_MRET, 12'h000, 64'd0);
    wait_results(RESULT_TIMEOUT);
    set_irq_lines(3'b010);
    @(negedge clk_i);
    wait_for_interrupt(8);
    read_trap_csrs();
    // Now in M-mode with mstatus.mie clear
    for (i = 0; i < 4; i++)
      send_cmd(OP_CSRRW, ADDR_MSCRATCH, rand_bits(64));
    wait_results(RESULT_TIMEOUT);
    set_irq_lines(3'b000);
    end_test();

    start_test("irq_priority");
    set_irq_lines(3'b111);
    send_cmd(OP_CSRRS, ADDR_MIE, 64'h888);
    send_cmd(OP_CSRRSI, ADDR_MSTATUS, 64'd8);
    wait_results(RESULT_TIMEOUT);
    wait_for_interrupt(8);
    tb_checks++;
    assert (last_cause == 4'd11)
    else
    begin
      tb_errors++;
      $display("Mismatch in %s: expected cause %0d, actual cause %0d", test_name, 11, last_cause);
    end
    set_irq_lines(3'b000);
    read_trap_csrs();
    end_test();

    start_test("counters");
    send_cmd(OP_CSRRW, ADDR_MINSTRET, rand_bits(64));
    wait_results(RESULT_TIMEOUT);
    k = int'(rand_bits(4)) + 5;
    instret_i = 1'b1;
    repeat (k) @(negedge clk_i);
    instret_i  = 1'b0;
    m_minstret = m_minstret + 64'(k);
    send_cmd(OP_CSRRS, ADDR_MINSTRET, 64'd0);
    wait_results(RESULT_TIMEOUT);
    send_cmd(OP_CSRRS, ADDR_MCYCLE, 64'd0);
    wait_results(RESULT_TIMEOUT);
    t0 = last_data;
    send_cmd(OP_CSRRS, ADDR_MCYCLE, 64'd0);
    wait_results(RESULT_TIMEOUT);
    t1 = last_data;
    tb_checks++;
    assert (t1 > t0)
    else
    begin
      tb_errors++;
      $display("mcycle did not increase in %s: first read %h, second read %h", test_name, t0, t1);
    end
    end_test();

    $display("Tests run: %0d, failed: %0d, checks: %0d, errors: %0d", tests_run, tests_failed,
             cmp_checks + tb_checks, cmp_errors + tb_errors);
    if (tests_failed == 0 && cmp_errors + tb_errors == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== hw/csr_top.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_top
  import csr_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  csr_cmd_t    csr_cmd_i,
  input  logic        csr_cmd_v_i,
  input  logic        timer_irq_i,
  input  logic        software_irq_i,
  input  logic        external_irq_i,
  input  logic        instret_i,
  output csr_result_t csr_result_o,
  output logic        result_v_o,
  output priv_e       priv_mode_o
);

  csr_stage_t stage;
  logic       stage_v;

  csr_decode u_csr_decode (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .csr_cmd_i  (csr_cmd_i),
    .csr_cmd_v_i(csr_cmd_v_i),
    .stage_o    (stage),
    .stage_v_o  (stage_v)
  );

  csr_exec #(
    .HART_ID(HART_ID)
  ) u_csr_exec (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .stage_i       (stage),
    .stage_v_i     (stage_v),
    .timer_irq_i   (timer_irq_i),
    .software_irq_i(software_irq_i),
    .external_irq_i(external_irq_i),
    .instret_i     (instret_i),
    .csr_result_o  (csr_result_o),
    .result_v_o    (result_v_o),
    .priv_mode_o   (priv_mode_o)
  );

endmodule

`default_nettype wire

// ==== hw/csr_exec.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_exec
  import csr_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)
(
  input  logic        clk_i,
  input  logic        rst_n_i,
  input  csr_stage_t  stage_i,
  input  logic        stage_v_i,
  input  logic        timer_irq_i,
  input  logic        software_irq_i,
  input  logic        external_irq_i,
  input  logic        instret_i,
  output csr_result_t csr_result_o,
  output logic        result_v_o,
  output priv_e       priv_mode_o
);

  priv_e           priv_q;
  priv_e           priv_n;
  logic [XLEN-1:0] rdata;
  logic [XLEN-1:0] src;
  logic [XLEN-1:0] wdata;
  logic [XLEN-1:0] mtvec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] next_pc;
  logic [XLEN-1:0] trap_tval;
  logic [3:0]      trap_cause;
  logic [3:0]      irq_cause;
  mstatus_t        mstatus;
  mip_t            mie;
  mip_t            mip;
  mip_t            irq_levels;
  logic            irq_v;
  logic            writes;
  logic            rmw_illegal;
  logic            is_mret;
  logic            illegal;
  logic            ecall;
  logic            exception;
  logic            interrupt;
  logic            trap;
  logic            mret;
  logic            we;
  csr_result_t     result_d;

  assign irq_levels = '{msi: software_irq_i, mti: timer_irq_i, mei: external_irq_i,
                        default: '0};

  assign src = stage_i.use_imm ? XLEN'(stage_i.cmd.data[4:0]) : stage_i.cmd.data;

  always_comb
  begin
    case (stage_i.cmd.op)
      OP_CSRRW, OP_CSRRWI: wdata = src;
      OP_CSRRS, OP_CSRRSI: wdata = rdata | src;
      OP_CSRRC, OP_CSRRCI: wdata = rdata & ~src;
      default:             wdata = rdata;
    endcase
  end

  // Set and clear with a zero source are pure reads
  assign writes = (stage_i.cmd.op inside {OP_CSRRW, OP_CSRRWI}) | (|src);

  assign rmw_illegal = ~stage_i.addr_known
                     | (stage_i.addr_priv > priv_q)
                     | (stage_i.addr_readonly & writes);
  assign is_mret     = (stage_i.cmd.op == OP_MRET);

  assign illegal   = stage_v_i & ((stage_i.is_rmw & rmw_illegal)
                                  | (is_mret & (priv_q != PRIV_M)));
  assign ecall     = stage_v_i & (stage_i.cmd.op == OP_ECALL);
  assign exception = illegal | ecall;
  // Interrupt squashes a command that does not trap by itself
  assign interrupt = stage_v_i & irq_v & ~exception;
  assign trap      = exception | interrupt;
  assign mret      = stage_v_i & is_mret & ~illegal & ~interrupt;
  assign we        = stage_v_i & stage_i.is_rmw & writes & ~trap;

  always_comb
  begin
    if (illegal)
      trap_cause = CAUSE_ILLEGAL;
    else if (ecall)
      trap_cause = (priv_q == PRIV_U) ? CAUSE_ECALL_U : CAUSE_ECALL_M;
    else
      trap_cause = irq_cause;
  end

  assign trap_tval = illegal ? XLEN'(stage_i.cmd.instr) : '0;

  always_comb
  begin
    priv_n  = priv_q;
    next_pc = '0;
    if (trap)
    begin
      priv_n  = PRIV_M;
      next_pc = {mtvec[XLEN-1:2], 2'b00};
    end
    else if (mret)
    begin
      priv_n  = mstatus.mpp;
      next_pc = mepc;
    end
  end

  always_comb
  begin
    result_d           = '0;
    result_d.data      = (stage_i.is_rmw & ~trap) ? rdata : '0;
    result_d.illegal   = illegal;
    result_d.exception = exception;
    result_d.interrupt = interrupt;
    result_d.eret      = mret;
    result_d.cause     = trap ? trap_cause : 4'd0;
    result_d.next_pc   = next_pc;
    result_d.priv_n    = priv_n;
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      priv_q       <= PRIV_M;
      result_v_o   <= 1'b0;
      csr_result_o <= '0;
    end
    else
    begin
      result_v_o <= stage_v_i;
      if (stage_v_i)
      begin
        priv_q       <= priv_n;
        csr_result_o <= result_d;
      end
    end
  end

  assign priv_mode_o = priv_q;

  csr_regfile #(
    .HART_ID(HART_ID)
  ) u_csr_regfile (
    .clk_i           (clk_i),
    .rst_n_i         (rst_n_i),
    .addr_i          (stage_i.cmd.addr),
    .wdata_i         (wdata),
    .we_i            (we),
    .trap_i          (trap),
    .trap_interrupt_i(interrupt),
    .trap_cause_i    (trap_cause),
    .trap_pc_i       (stage_i.cmd.pc),
    .trap_tval_i     (trap_tval),
    .mret_i          (mret),
    .priv_i          (priv_q),
    .irq_levels_i    (irq_levels),
    .instret_i       (instret_i),
    .rdata_o         (rdata),
    .mstatus_o       (mstatus),
    .mie_o           (mie),
    .mip_o           (mip),
    .mtvec_o         (mtvec),
    .mepc_o          (mepc)
  );

  irq_select u_irq_select (
    .mstatus_i  (mstatus),
    .mie_i      (mie),
    .mip_i      (mip),
    .priv_i     (priv_q),
    .irq_v_o    (irq_v),
    .irq_cause_o(irq_cause)
  );

endmodule

`default_nettype wire

// ==== hw/csr_decode.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_decode
  import csr_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_n_i,
  input  csr_cmd_t   csr_cmd_i,
  input  logic       csr_cmd_v_i,
  output csr_stage_t stage_o,
  output logic       stage_v_o
);

  csr_stage_t stage_d;

  always_comb
  begin
    stage_d.cmd     = csr_cmd_i;
    stage_d.is_rmw  = csr_cmd_i.op inside {OP_CSRRW, OP_CSRRS, OP_CSRRC,
                                           OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};
    stage_d.use_imm = csr_cmd_i.op inside {OP_CSRRWI, OP_CSRRSI, OP_CSRRCI};

    stage_d.addr_known = csr_cmd_i.addr inside {
      ADDR_MSTATUS, ADDR_MISA, ADDR_MIE, ADDR_MTVEC,
      ADDR_MSCRATCH, ADDR_MEPC, ADDR_MCAUSE, ADDR_MTVAL, ADDR_MIP,
      ADDR_MCYCLE, ADDR_MINSTRET,
      ADDR_MVENDORID, ADDR_MARCHID, ADDR_MIMPID, ADDR_MHARTID
    };

    // Bits 11:10 both set mark read-only space
    stage_d.addr_readonly = &csr_cmd_i.addr[11:10];
    stage_d.addr_priv     = csr_cmd_i.addr[9:8];
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
      stage_v_o <= 1'b0;
    else
      stage_v_o <= csr_cmd_v_i;
  end

  always_ff @(posedge clk_i)
  begin
    if (csr_cmd_v_i)
      stage_o <= stage_d;
  end

endmodule

`default_nettype wire

// ==== hw/csr_regfile.sv ====
`timescale 1ns/10ps
`default_nettype none

module csr_regfile
  import csr_pkg::*;
#(
  parameter int unsigned HART_ID = 0
)
(
  input  logic                  clk_i,
  input  logic                  rst_n_i,
  input  logic [CSR_ADDR_W-1:0] addr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic                  we_i,
  input  logic                  trap_i,
  input  logic                  trap_interrupt_i,
  input  logic [3:0]            trap_cause_i,
  input  logic [XLEN-1:0]       trap_pc_i,
  input  logic [XLEN-1:0]       trap_tval_i,
  input  logic                  mret_i,
  input  priv_e                 priv_i,
  input  mip_t                  irq_levels_i,
  input  logic                  instret_i,
  output logic [XLEN-1:0]       rdata_o,
  output mstatus_t              mstatus_o,
  output mip_t                  mie_o,
  output mip_t                  mip_o,
  output logic [XLEN-1:0]       mtvec_o,
  output logic [XLEN-1:0]       mepc_o
);

  mstatus_t        mstatus_q;
  mstatus_t        mstatus_d;
  mstatus_t        mstatus_wr;
  mip_t            mie_q;
  mip_t            mie_d;
  mip_t            mie_wr;
  mip_t            mip_q;
  logic [XLEN-1:0] mtvec_q;
  logic [XLEN-1:0] mtvec_d;
  logic [XLEN-1:0] mscratch_q;
  logic [XLEN-1:0] mscratch_d;
  logic [XLEN-1:0] mepc_q;
  logic [XLEN-1:0] mepc_d;
  logic [XLEN-1:0] mcause_q;
  logic [XLEN-1:0] mcause_d;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mtval_d;
  logic [XLEN-1:0] mcycle_q;
  logic [XLEN-1:0] mcycle_d;
  logic [XLEN-1:0] minstret_q;
  logic [XLEN-1:0] minstret_d;

  always_comb
  begin
    mstatus_wr = mstatus_t'(wdata_i);
    mie_wr     = mip_t'(wdata_i);
    mstatus_d  = mstatus_q;
    mie_d      = mie_q;
    mtvec_d    = mtvec_q;
    mscratch_d = mscratch_q;
    mepc_d     = mepc_q;
    mcause_d   = mcause_q;
    mtval_d    = mtval_q;
    mcycle_d   = mcycle_q + XLEN'(1);
    minstret_d = minstret_q + XLEN'(instret_i);

    if (we_i)
    begin
      case (addr_i)
        ADDR_MSTATUS:
        begin
          mstatus_d      = '0;
          mstatus_d.mie  = mstatus_wr.mie;
          mstatus_d.mpie = mstatus_wr.mpie;
          // Only M and U exist so other values fall back to U
          mstatus_d.mpp  = (mstatus_wr.mpp == PRIV_M) ? PRIV_M : PRIV_U;
        end
        ADDR_MIE:
        begin
          mie_d     = '0;
          mie_d.msi = mie_wr.msi;
          mie_d.mti = mie_wr.mti;
          mie_d.mei = mie_wr.mei;
        end
        ADDR_MTVEC:    mtvec_d    = wdata_i;
        ADDR_MSCRATCH: mscratch_d = wdata_i;
        ADDR_MEPC:     mepc_d     = wdata_i;
        ADDR_MCAUSE:   mcause_d   = wdata_i;
        ADDR_MTVAL:    mtval_d    = wdata_i;
        ADDR_MCYCLE:   mcycle_d   = wdata_i;
        ADDR_MINSTRET: minstret_d = wdata_i;
        // mip follows the interrupt lines only
        default:       ;
      endcase
    end

    if (trap_i)
    begin
      mstatus_d.mpp  = priv_i;
      mstatus_d.mpie = mstatus_q.mie;
      mstatus_d.mie  = 1'b0;
      mepc_d         = trap_pc_i;
      mcause_d       = {trap_interrupt_i, {(XLEN-5){1'b0}}, trap_cause_i};
      mtval_d        = trap_tval_i;
    end
    else if (mret_i)
    begin
      mstatus_d.mie  = mstatus_q.mpie;
      mstatus_d.mpie = 1'b1;
      mstatus_d.mpp  = PRIV_U;
    end
  end

  always_comb
  begin
    case (addr_i)
      ADDR_MSTATUS:   rdata_o = mstatus_q;
      ADDR_MISA:      rdata_o = MISA_VALUE;
      ADDR_MIE:       rdata_o = mie_q;
      ADDR_MTVEC:     rdata_o = mtvec_q;
      ADDR_MSCRATCH:  rdata_o = mscratch_q;
      ADDR_MEPC:      rdata_o = mepc_q;
      ADDR_MCAUSE:    rdata_o = mcause_q;
      ADDR_MTVAL:     rdata_o = mtval_q;
      ADDR_MIP:       rdata_o = mip_q;
      ADDR_MCYCLE:    rdata_o = mcycle_q;
      ADDR_MINSTRET:  rdata_o = minstret_q;
      ADDR_MVENDORID: rdata_o = '0;
      ADDR_MARCHID:   rdata_o = MARCHID_VALUE;
      ADDR_MIMPID:    rdata_o = MIMPID_VALUE;
      ADDR_MHARTID:   rdata_o = XLEN'(HART_ID);
      default:        rdata_o = '0;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      mstatus_q  <= '0;
      mie_q      <= '0;
      mip_q      <= '0;
      mtvec_q    <= '0;
      mscratch_q <= '0;
      mepc_q     <= '0;
      mcause_q   <= '0;
      mtval_q    <= '0;
      mcycle_q   <= '0;
      minstret_q <= '0;
    end
    else
    begin
      mstatus_q  <= mstatus_d;
      mie_q      <= mie_d;
      mip_q      <= irq_levels_i;
      mtvec_q    <= mtvec_d;
      mscratch_q <= mscratch_d;
      mepc_q     <= mepc_d;
      mcause_q   <= mcause_d;
      mtval_q    <= mtval_d;
      mcycle_q   <= mcycle_d;
      minstret_q <= minstret_d;
    end
  end

  assign mstatus_o = mstatus_q;
  assign mie_o     = mie_q;
  assign mip_o     = mip_q;
  assign mtvec_o   = mtvec_q;
  assign mepc_o    = mepc_q;

endmodule

`default_nettype wire

// ==== hw/irq_select.sv ====
`timescale 1ns/10ps
`default_nettype none

module irq_select
  import csr_pkg::*;
(
  input  mstatus_t   mstatus_i,
  input  mip_t       mie_i,
  input  mip_t       mip_i,
  input  priv_e      priv_i,
  output logic       irq_v_o,
  output logic [3:0] irq_cause_o
);

  logic gie;
  logic msi_v;
  logic mti_v;
  logic mei_v;

  // U-mode code can always be interrupted
  assign gie = (priv_i == PRIV_M) ? mstatus_i.mie : 1'b1;

  assign msi_v = gie & mie_i.msi & mip_i.msi;
  assign mti_v = gie & mie_i.mti & mip_i.mti;
  assign mei_v = gie & mie_i.mei & mip_i.mei;

  assign irq_v_o = msi_v | mti_v | mei_v;

  // External first, then software, then timer
  always_comb
  begin
    if (mei_v)
      irq_cause_o = IRQ_MEI;
    else if (msi_v)
      irq_cause_o = IRQ_MSI;
    else if (mti_v)
      irq_cause_o = IRQ_MTI;
    else
      irq_cause_o = 4'd0;
  end

endmodule

`default_nettype wire

// ==== hw/csr_pkg.sv ====
`default_nettype none

package csr_pkg;

  localparam int XLEN       = 64;
  localparam int CSR_ADDR_W = 12;

  typedef enum logic [1:0] {
    PRIV_U = 2'd0,
    PRIV_M = 2'd3
  } priv_e;

  typedef enum logic [3:0] {
    OP_CSRRW,
    OP_CSRRS,
    OP_CSRRC,
    OP_CSRRWI,
    OP_CSRRSI,
    OP_CSRRCI,
    OP_ECALL,
    OP_MRET,
    OP_NONE
  } csr_op_e;

  localparam logic [CSR_ADDR_W-1:0] ADDR_MSTATUS   = 12'h300;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MISA      = 12'h301;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIE       = 12'h304;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVEC     = 12'h305;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MSCRATCH  = 12'h340;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MEPC      = 12'h341;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCAUSE    = 12'h342;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MTVAL     = 12'h343;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIP       = 12'h344;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MCYCLE    = 12'hb00;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MINSTRET  = 12'hb02;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MVENDORID = 12'hf11;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MARCHID   = 12'hf12;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MIMPID    = 12'hf13;
  localparam logic [CSR_ADDR_W-1:0] ADDR_MHARTID   = 12'hf14;

  localparam logic [3:0] CAUSE_ILLEGAL = 4'd2;
  localparam logic [3:0] CAUSE_ECALL_U = 4'd8;
  localparam logic [3:0] CAUSE_ECALL_M = 4'd11;
  localparam logic [3:0] IRQ_MSI       = 4'd3;
  localparam logic [3:0] IRQ_MTI       = 4'd7;
  localparam logic [3:0] IRQ_MEI       = 4'd11;

  // MXL of 2 with extensions A I M U
  localparam logic [XLEN-1:0] MISA_VALUE    = {2'b10, 36'b0, 26'h101101};
  localparam logic [XLEN-1:0] MARCHID_VALUE = 64'd13;
  localparam logic [XLEN-1:0] MIMPID_VALUE  = 64'd1;

  typedef struct packed {
    csr_op_e               op;
    logic [CSR_ADDR_W-1:0] addr;
    logic [XLEN-1:0]       data;
    logic [XLEN-1:0]       pc;
    logic [31:0]           instr;
  } csr_cmd_t;

  typedef struct packed {
    csr_cmd_t   cmd;
    logic       is_rmw;
    logic       use_imm;
    logic       addr_known;
    logic       addr_readonly;
    logic [1:0] addr_priv;
  } csr_stage_t;

  typedef struct packed {
    logic [XLEN-1:0] data;
    logic            illegal;
    logic            exception;
    logic            interrupt;
    logic            eret;
    logic [3:0]      cause;
    logic [XLEN-1:0] next_pc;
    priv_e           priv_n;
  } csr_result_t;

  typedef struct packed {
    logic [XLEN-14:0] rsvd_hi;
    priv_e            mpp;
    logic [2:0]       rsvd_10_8;
    logic             mpie;
    logic [2:0]       rsvd_6_4;
    logic             mie;
    logic [2:0]       rsvd_2_0;
  } mstatus_t;

  // Shared layout of mie and mip
  typedef struct packed {
    logic [XLEN-13:0] rsvd_hi;
    logic             mei;
    logic [2:0]       rsvd_10_8;
    logic             mti;
    logic [2:0]       rsvd_6_4;
    logic             msi;
    logic [2:0]       rsvd_2_0;
  } mip_t;

endpackage

`default_nettype wire
